/* design/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// port and group counts.
`define MEM_NUM_RT 2
`define MEM_NUM_GROUP 4

// word address, group field starts at bit 10.
`define MEM_ADDR_W 12
`define MEM_GROUP_LSB 10

// 256 rows per bank.
`define MEM_ROW_W 8

// a line is four words, word 0 in the top bits.
`define MEM_WORD_W 32
`define MEM_LINE_W 128

`endif

/* design/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  // request opcode, as carried from the ports to the banks.
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // front end states.
  typedef enum logic [1:0] {
    PORT_IDLE       = 2'd0,
    PORT_WAIT_GRANT = 2'd1,
    PORT_ACCESS     = 2'd2,
    PORT_RESPOND    = 2'd3
  } port_state_e;

endpackage

`default_nettype wire

/* design/sp_ram.sv */
`default_nettype none
`include "mem_consts.svh"

module sp_ram (
  input  logic                   clk,
  input  logic                   we,
  input  logic [`MEM_ROW_W-1:0]  addr,
  input  logic [`MEM_WORD_W-1:0] data,
  output logic [`MEM_WORD_W-1:0] q
);

  logic [`MEM_WORD_W-1:0] mem [2**`MEM_ROW_W];

  // read returns the old word on a write cycle.
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= data;
    end
    q <= mem[addr];
  end

endmodule

`default_nettype wire

/* design/bank_group.sv */
`default_nettype none
`include "mem_consts.svh"

module bank_group (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      en,
  input  mem_pkg::mem_op_e          op,
  input  logic [`MEM_GROUP_LSB-1:0] addr,
  input  logic [`MEM_LINE_W-1:0]    wdata,
  output logic [`MEM_LINE_W-1:0]    rdata
);
  import mem_pkg::*;

  localparam int NUM_BANK = `MEM_LINE_W / `MEM_WORD_W;
  localparam int BANK_W = $clog2(NUM_BANK);

  logic [BANK_W-1:0]      start_bank;
  logic [`MEM_ROW_W-1:0]  row_in  [NUM_BANK];
  logic [`MEM_WORD_W-1:0] data_in [NUM_BANK];

  logic                   we_q;
  logic [`MEM_ROW_W-1:0]  row_q  [NUM_BANK];
  logic [`MEM_WORD_W-1:0] data_q [NUM_BANK];
  logic [BANK_W-1:0]      sb_q;
  logic [BANK_W-1:0]      sb_qq;
  logic [`MEM_WORD_W-1:0] q [NUM_BANK];

  assign start_bank = addr[BANK_W-1:0];

  // bank b takes word (b - start) of the line.
  always_comb begin
    logic [BANK_W-1:0]         k;
    logic [`MEM_GROUP_LSB-1:0] off;
    for (int b = 0; b < NUM_BANK; b++) begin
      k = BANK_W'(b) - start_bank;
      // offset wraps inside the group.
      off = addr + `MEM_GROUP_LSB'(k);
      row_in[b] = off[`MEM_GROUP_LSB-1:BANK_W];
      data_in[b] = wdata[`MEM_LINE_W-1-`MEM_WORD_W*k -: `MEM_WORD_W];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
      sb_q <= '0;
      sb_qq <= '0;
      for (int b = 0; b < NUM_BANK; b++) begin
        row_q[b] <= '0;
        data_q[b] <= '0;
      end
    end else begin
      we_q <= en && (op == MEM_WRITE);
      sb_q <= start_bank;
      // lines up with the registered bank output.
      sb_qq <= sb_q;
      for (int b = 0; b < NUM_BANK; b++) begin
        row_q[b] <= row_in[b];
        data_q[b] <= data_in[b];
      end
    end
  end

  for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
    sp_ram u_ram (
      .clk  (clk),
      .we   (we_q),
      .addr (row_q[b]),
      .data (data_q[b]),
      .q    (q[b])
    );
  end

  // undo the rotation, word k comes from bank start + k.
  always_comb begin
    logic [BANK_W-1:0] b;
    for (int k = 0; k < NUM_BANK; k++) begin
      b = sb_qq + BANK_W'(k);
      rdata[`MEM_LINE_W-1-`MEM_WORD_W*k -: `MEM_WORD_W] = q[b];
    end
  end

endmodule

`default_nettype wire

/* design/bank_arbiter.sv */
`default_nettype none
`include "mem_consts.svh"

module bank_arbiter (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [`MEM_NUM_RT-1:0]            rt_req,
  input  mem_pkg::mem_op_e                  rt_op [`MEM_NUM_RT],
  input  logic [`MEM_ADDR_W-1:0]            rt_addr [`MEM_NUM_RT],
  input  logic [`MEM_LINE_W-1:0]            rt_wdata [`MEM_NUM_RT],
  input  logic                              mc_req,
  input  logic [`MEM_ADDR_W-1:0]            mc_addr,
  output logic [`MEM_NUM_RT-1:0]            rt_gnt,
  output logic                              mc_gnt,
  output logic [$clog2(`MEM_NUM_GROUP):0]   rt_gnt_d [`MEM_NUM_RT],
  output logic [$clog2(`MEM_NUM_GROUP):0]   mc_gnt_d,
  output logic [`MEM_NUM_GROUP-1:0]         grp_en,
  output mem_pkg::mem_op_e                  grp_op [`MEM_NUM_GROUP],
  output logic [`MEM_GROUP_LSB-1:0]         grp_addr [`MEM_NUM_GROUP],
  output logic [`MEM_LINE_W-1:0]            grp_wdata [`MEM_NUM_GROUP]
);
  import mem_pkg::*;

  localparam int GRP_W = $clog2(`MEM_NUM_GROUP);
  localparam int PTR_W = $clog2(`MEM_NUM_RT);

  logic [GRP_W-1:0]          rt_grp [`MEM_NUM_RT];
  logic [GRP_W-1:0]          mc_grp;
  logic [PTR_W-1:0]          last_rt [`MEM_NUM_GROUP];
  logic [`MEM_NUM_GROUP-1:0] pick_mc;
  logic [`MEM_NUM_GROUP-1:0] pick_rt;
  logic [PTR_W-1:0]          pick_idx [`MEM_NUM_GROUP];

  assign mc_grp = mc_addr[`MEM_ADDR_W-1:`MEM_GROUP_LSB];

  always_comb begin
    for (int r = 0; r < `MEM_NUM_RT; r++) begin
      rt_grp[r] = rt_addr[r][`MEM_ADDR_W-1:`MEM_GROUP_LSB];
    end
  end

  // mc first, then rt ports starting after the last one served.
  always_comb begin
    int idx;
    for (int g = 0; g < `MEM_NUM_GROUP; g++) begin
      pick_mc[g] = mc_req && (mc_grp == GRP_W'(g));
      pick_rt[g] = 1'b0;
      pick_idx[g] = last_rt[g];
      for (int i = 1; i <= `MEM_NUM_RT; i++) begin
        idx = (int'(last_rt[g]) + i) % `MEM_NUM_RT;
        if (!pick_mc[g] && !pick_rt[g] && rt_req[idx] && (rt_grp[idx] == GRP_W'(g))) begin
          pick_rt[g] = 1'b1;
          pick_idx[g] = PTR_W'(idx);
        end
      end
    end
  end

  always_comb begin
    mc_gnt = |pick_mc;
    rt_gnt = '0;
    for (int g = 0; g < `MEM_NUM_GROUP; g++) begin
      if (pick_rt[g]) begin
        rt_gnt[pick_idx[g]] = 1'b1;
      end
    end
  end

  // steer the winner onto the group inputs.
  always_comb begin
    for (int g = 0; g < `MEM_NUM_GROUP; g++) begin
      grp_en[g] = pick_mc[g] | pick_rt[g];
      if (pick_mc[g]) begin
        grp_op[g] = MEM_READ;
        grp_addr[g] = mc_addr[`MEM_GROUP_LSB-1:0];
        grp_wdata[g] = '0;
      end else begin
        grp_op[g] = rt_op[pick_idx[g]];
        grp_addr[g] = rt_addr[pick_idx[g]][`MEM_GROUP_LSB-1:0];
        grp_wdata[g] = rt_wdata[pick_idx[g]];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int g = 0; g < `MEM_NUM_GROUP; g++) begin
        last_rt[g] <= '0;
      end
      for (int r = 0; r < `MEM_NUM_RT; r++) begin
        rt_gnt_d[r] <= '0;
      end
      mc_gnt_d <= '0;
    end else begin
      for (int g = 0; g < `MEM_NUM_GROUP; g++) begin
        if (pick_rt[g]) begin
          last_rt[g] <= pick_idx[g];
        end
      end
      // valid flag on top, group index below.
      for (int r = 0; r < `MEM_NUM_RT; r++) begin
        rt_gnt_d[r] <= {rt_gnt[r], rt_grp[r]};
      end
      mc_gnt_d <= {mc_gnt, mc_grp};
    end
  end

endmodule

`default_nettype wire

/* design/rt_port.sv */
`default_nettype none
`include "mem_consts.svh"

module rt_port (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            req_valid,
  output logic                            req_ready,
  input  mem_pkg::mem_op_e                req_op,
  input  logic [`MEM_ADDR_W-1:0]          req_addr,
  input  logic [`MEM_LINE_W-1:0]          req_wdata,
  output logic                            rsp_valid,
  input  logic                            rsp_ready,
  output logic [`MEM_LINE_W-1:0]          rsp_rdata,
  output logic                            bus_req,
  output mem_pkg::mem_op_e                bus_op,
  output logic [`MEM_ADDR_W-1:0]          bus_addr,
  output logic [`MEM_LINE_W-1:0]          bus_wdata,
  input  logic                            bus_gnt,
  input  logic [$clog2(`MEM_NUM_GROUP):0] gnt_d,
  input  logic [`MEM_LINE_W-1:0]          grp_rdata [`MEM_NUM_GROUP]
);
  import mem_pkg::*;

  localparam int GRP_W = $clog2(`MEM_NUM_GROUP);

  port_state_e            state;
  logic                   data_phase;
  mem_op_e                op_q;
  logic [`MEM_ADDR_W-1:0] addr_q;
  logic [`MEM_LINE_W-1:0] wdata_q;
  logic [GRP_W-1:0]       src_grp;
  logic [`MEM_LINE_W-1:0] rdata_q;

  assign req_ready = (state == PORT_IDLE);
  assign rsp_valid = (state == PORT_RESPOND);
  assign rsp_rdata = rdata_q;
  assign bus_req = (state == PORT_WAIT_GRANT);
  assign bus_op = op_q;
  assign bus_addr = addr_q;
  assign bus_wdata = wdata_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= PORT_IDLE;
      data_phase <= 1'b0;
    end else begin
      case (state)
        PORT_IDLE: begin
          if (req_valid) begin
            state <= PORT_WAIT_GRANT;
          end
        end
        PORT_WAIT_GRANT: begin
          if (bus_gnt) begin
            state <= PORT_ACCESS;
            data_phase <= 1'b0;
          end
        end
        PORT_ACCESS: begin
          // a write is in the ram after one cycle.
          if (op_q == MEM_WRITE) begin
            state <= PORT_IDLE;
          end else if (data_phase) begin
            state <= PORT_RESPOND;
          end else if (gnt_d[GRP_W]) begin
            data_phase <= 1'b1;
          end
        end
        default: begin
          if (rsp_ready) begin
            state <= PORT_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      op_q <= req_op;
      addr_q <= req_addr;
      wdata_q <= req_wdata;
    end
    if (state == PORT_ACCESS && !data_phase) begin
      src_grp <= gnt_d[GRP_W-1:0];
    end
    if (state == PORT_ACCESS && data_phase) begin
      rdata_q <= grp_rdata[src_grp];
    end
  end

endmodule

`default_nettype wire

/* design/mc_port.sv */
`default_nettype none
`include "mem_consts.svh"

module mc_port (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            req_valid,
  output logic                            req_ready,
  input  logic [`MEM_ADDR_W-1:0]          req_addr,
  output logic                            rsp_valid,
  input  logic                            rsp_ready,
  output logic [`MEM_LINE_W-1:0]          rsp_rdata,
  output logic                            bus_req,
  output logic [`MEM_ADDR_W-1:0]          bus_addr,
  input  logic                            bus_gnt,
  input  logic [$clog2(`MEM_NUM_GROUP):0] gnt_d,
  input  logic [`MEM_LINE_W-1:0]          grp_rdata [`MEM_NUM_GROUP]
);
  import mem_pkg::*;

  localparam int GRP_W = $clog2(`MEM_NUM_GROUP);

  port_state_e            state;
  logic                   data_phase;
  logic [`MEM_ADDR_W-1:0] addr_q;
  logic [GRP_W-1:0]       src_grp;
  logic [`MEM_LINE_W-1:0] rdata_q;

  assign req_ready = (state == PORT_IDLE);
  assign rsp_valid = (state == PORT_RESPOND);
  assign rsp_rdata = rdata_q;
  assign bus_req = (state == PORT_WAIT_GRANT);
  assign bus_addr = addr_q;

  // reads only, so every access ends in a response.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= PORT_IDLE;
      data_phase <= 1'b0;
    end else begin
      case (state)
        PORT_IDLE: begin
          if (req_valid) begin
            state <= PORT_WAIT_GRANT;
          end
        end
        PORT_WAIT_GRANT: begin
          if (bus_gnt) begin
            state <= PORT_ACCESS;
            data_phase <= 1'b0;
          end
        end
        PORT_ACCESS: begin
          if (data_phase) begin
            state <= PORT_RESPOND;
          end else if (gnt_d[GRP_W]) begin
            data_phase <= 1'b1;
          end
        end
        default: begin
          if (rsp_ready) begin
            state <= PORT_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      addr_q <= req_addr;
    end
    // group index from the delayed grant.
    if (state == PORT_ACCESS && !data_phase) begin
      src_grp <= gnt_d[GRP_W-1:0];
    end
    if (state == PORT_ACCESS && data_phase) begin
      rdata_q <= grp_rdata[src_grp];
    end
  end

endmodule

`default_nettype wire

/* design/mem_main.sv */
`default_nettype none
`include "mem_consts.svh"

module mem_main (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`MEM_NUM_RT-1:0] rt_req_valid,
  output logic [`MEM_NUM_RT-1:0] rt_req_ready,
  input  mem_pkg::mem_op_e       rt_req_op [`MEM_NUM_RT],
  input  logic [`MEM_ADDR_W-1:0] rt_req_addr [`MEM_NUM_RT],
  input  logic [`MEM_LINE_W-1:0] rt_req_wdata [`MEM_NUM_RT],
  output logic [`MEM_NUM_RT-1:0] rt_rsp_valid,
  input  logic [`MEM_NUM_RT-1:0] rt_rsp_ready,
  output logic [`MEM_LINE_W-1:0] rt_rsp_rdata [`MEM_NUM_RT],
  input  logic                   mc_req_valid,
  output logic                   mc_req_ready,
  input  logic [`MEM_ADDR_W-1:0] mc_req_addr,
  output logic                   mc_rsp_valid,
  input  logic                   mc_rsp_ready,
  output logic [`MEM_LINE_W-1:0] mc_rsp_rdata
);
  import mem_pkg::*;

  localparam int GRP_W = $clog2(`MEM_NUM_GROUP);

  logic [`MEM_NUM_RT-1:0]    rt_bus_req;
  mem_op_e                   rt_bus_op [`MEM_NUM_RT];
  logic [`MEM_ADDR_W-1:0]    rt_bus_addr [`MEM_NUM_RT];
  logic [`MEM_LINE_W-1:0]    rt_bus_wdata [`MEM_NUM_RT];
  logic [`MEM_NUM_RT-1:0]    rt_bus_gnt;
  logic [GRP_W:0]            rt_gnt_d [`MEM_NUM_RT];
  logic                      mc_bus_req;
  logic [`MEM_ADDR_W-1:0]    mc_bus_addr;
  logic                      mc_bus_gnt;
  logic [GRP_W:0]            mc_gnt_d;
  logic [`MEM_NUM_GROUP-1:0] grp_en;
  mem_op_e                   grp_op [`MEM_NUM_GROUP];
  logic [`MEM_GROUP_LSB-1:0] grp_addr [`MEM_NUM_GROUP];
  logic [`MEM_LINE_W-1:0]    grp_wdata [`MEM_NUM_GROUP];
  logic [`MEM_LINE_W-1:0]    grp_rdata [`MEM_NUM_GROUP];

  for (genvar r = 0; r < `MEM_NUM_RT; r++) begin : g_rt
    rt_port u_rt_port (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (rt_req_valid[r]),
      .req_ready (rt_req_ready[r]),
      .req_op    (rt_req_op[r]),
      .req_addr  (rt_req_addr[r]),
      .req_wdata (rt_req_wdata[r]),
      .rsp_valid (rt_rsp_valid[r]),
      .rsp_ready (rt_rsp_ready[r]),
      .rsp_rdata (rt_rsp_rdata[r]),
      .bus_req   (rt_bus_req[r]),
      .bus_op    (rt_bus_op[r]),
      .bus_addr  (rt_bus_addr[r]),
      .bus_wdata (rt_bus_wdata[r]),
      .bus_gnt   (rt_bus_gnt[r]),
      .gnt_d     (rt_gnt_d[r]),
      .grp_rdata (grp_rdata)
    );
  end

  mc_port u_mc_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (mc_req_valid),
    .req_ready (mc_req_ready),
    .req_addr  (mc_req_addr),
    .rsp_valid (mc_rsp_valid),
    .rsp_ready (mc_rsp_ready),
    .rsp_rdata (mc_rsp_rdata),
    .bus_req   (mc_bus_req),
    .bus_addr  (mc_bus_addr),
    .bus_gnt   (mc_bus_gnt),
    .gnt_d     (mc_gnt_d),
    .grp_rdata (grp_rdata)
  );

  bank_arbiter u_arbiter (
    .clk       (clk),
    .rst_n     (rst_n),
    .rt_req    (rt_bus_req),
    .rt_op     (rt_bus_op),
    .rt_addr   (rt_bus_addr),
    .rt_wdata  (rt_bus_wdata),
    .mc_req    (mc_bus_req),
    .mc_addr   (mc_bus_addr),
    .rt_gnt    (rt_bus_gnt),
    .mc_gnt    (mc_bus_gnt),
    .rt_gnt_d  (rt_gnt_d),
    .mc_gnt_d  (mc_gnt_d),
    .grp_en    (grp_en),
    .grp_op    (grp_op),
    .grp_addr  (grp_addr),
    .grp_wdata (grp_wdata)
  );

  for (genvar g = 0; g < `MEM_NUM_GROUP; g++) begin : g_grp
    bank_group u_group (
      .clk   (clk),
      .rst_n (rst_n),
      .en    (grp_en[g]),
      .op    (grp_op[g]),
      .addr  (grp_addr[g]),
      .wdata (grp_wdata[g]),
      .rdata (grp_rdata[g])
    );
  end

endmodule

`default_nettype wire

/* verif/mem_main_tb.sv */
`default_nettype none
`include "mem_consts.svh"

module mem_main_tb;
  import mem_pkg::*;

  localparam int MC = `MEM_NUM_RT;
  localparam int TIMEOUT = 200;
  localparam int GRP_W = $clog2(`MEM_NUM_GROUP);

  logic                   clk;
  logic                   rst_n;
  logic [`MEM_NUM_RT-1:0] rt_req_valid;
  logic [`MEM_NUM_RT-1:0] rt_req_ready;
  mem_op_e                rt_req_op [`MEM_NUM_RT];
  logic [`MEM_ADDR_W-1:0] rt_req_addr [`MEM_NUM_RT];
  logic [`MEM_LINE_W-1:0] rt_req_wdata [`MEM_NUM_RT];
  logic [`MEM_NUM_RT-1:0] rt_rsp_valid;
  logic [`MEM_NUM_RT-1:0] rt_rsp_ready;
  logic [`MEM_LINE_W-1:0] rt_rsp_rdata [`MEM_NUM_RT];
  logic                   mc_req_valid;
  logic                   mc_req_ready;
  logic [`MEM_ADDR_W-1:0] mc_req_addr;
  logic                   mc_rsp_valid;
  logic                   mc_rsp_ready;
  logic [`MEM_LINE_W-1:0] mc_rsp_rdata;

  // reference memory with one entry per word address.
  logic [`MEM_WORD_W-1:0] model [2**`MEM_ADDR_W];
  int  seed;
  int  errors;
  int  err_base;
  int  tests_ok;
  int  tests_bad;
  time done_time [`MEM_NUM_RT+1];

  mem_main dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .rt_req_valid (rt_req_valid),
    .rt_req_ready (rt_req_ready),
    .rt_req_op    (rt_req_op),
    .rt_req_addr  (rt_req_addr),
    .rt_req_wdata (rt_req_wdata),
    .rt_rsp_valid (rt_rsp_valid),
    .rt_rsp_ready (rt_rsp_ready),
    .rt_rsp_rdata (rt_rsp_rdata),
    .mc_req_valid (mc_req_valid),
    .mc_req_ready (mc_req_ready),
    .mc_req_addr  (mc_req_addr),
    .mc_rsp_valid (mc_rsp_valid),
    .mc_rsp_ready (mc_rsp_ready),
    .mc_rsp_rdata (mc_rsp_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [`MEM_ADDR_W-1:0] make_addr(input int g, input int off);
    return {GRP_W'(g), `MEM_GROUP_LSB'(off)};
  endfunction

  // word k stays in the start's group and wraps at offset 1024.
  function automatic logic [`MEM_ADDR_W-1:0] word_addr(input logic [`MEM_ADDR_W-1:0] start,
                                                       input int k);
    logic [`MEM_GROUP_LSB-1:0] off;
    off = start[`MEM_GROUP_LSB-1:0] + `MEM_GROUP_LSB'(k);
    return {start[`MEM_ADDR_W-1:`MEM_GROUP_LSB], off};
  endfunction

  function automatic logic [`MEM_LINE_W-1:0] model_line(input logic [`MEM_ADDR_W-1:0] start);
    logic [`MEM_LINE_W-1:0] line;
    for (int k = 0; k < 4; k++) begin
      line[`MEM_LINE_W-1-`MEM_WORD_W*k -: `MEM_WORD_W] = model[word_addr(start, k)];
    end
    return line;
  endfunction

  function automatic void model_write(input logic [`MEM_ADDR_W-1:0] start,
                                      input logic [`MEM_LINE_W-1:0] line);
    for (int k = 0; k < 4; k++) begin
      model[word_addr(start, k)] = line[`MEM_LINE_W-1-`MEM_WORD_W*k -: `MEM_WORD_W];
    end
  endfunction

  function automatic logic [`MEM_LINE_W-1:0] fill_line(input logic [`MEM_ADDR_W-1:0] start);
    logic [`MEM_LINE_W-1:0] line;
    logic [`MEM_ADDR_W-1:0] a;
    for (int k = 0; k < 4; k++) begin
      a = word_addr(start, k);
      line[`MEM_LINE_W-1-`MEM_WORD_W*k -: `MEM_WORD_W] = {a, 8'h5a, ~a};
    end
    return line;
  endfunction

  function automatic logic [`MEM_LINE_W-1:0] rand_line();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic logic req_ready_of(input int p);
    return (p == MC) ? mc_req_ready : rt_req_ready[p];
  endfunction

  function automatic logic rsp_valid_of(input int p);
    return (p == MC) ? mc_rsp_valid : rt_rsp_valid[p];
  endfunction

  function automatic logic [`MEM_LINE_W-1:0] rsp_rdata_of(input int p);
    return (p == MC) ? mc_rsp_rdata : rt_rsp_rdata[p];
  endfunction

  task automatic check_line(input string what, input logic [`MEM_LINE_W-1:0] got,
                            input logic [`MEM_LINE_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_ready(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s did not happen within %0d cycles, time %0t", what, TIMEOUT, $time);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic wait_cycle(inout int n, input string what);
    @(posedge clk);
    #2;
    n++;
    if (n >= TIMEOUT) begin
      stop_on_timeout(what);
    end
  endtask

  task automatic drive_req(input int p, input logic v, input mem_op_e op,
                           input logic [`MEM_ADDR_W-1:0] addr,
                           input logic [`MEM_LINE_W-1:0] wdata);
    if (p == MC) begin
      mc_req_valid = v;
      mc_req_addr = addr;
    end else begin
      rt_req_valid[p] = v;
      rt_req_op[p] = op;
      rt_req_addr[p] = addr;
      rt_req_wdata[p] = wdata;
    end
  endtask

  task automatic set_rsp_ready(input int p, input logic v);
    if (p == MC) begin
      mc_rsp_ready = v;
    end else begin
      rt_rsp_ready[p] = v;
    end
  endtask

  // one request on port p, from 2 time units after an edge to 2 after a later one.
  task automatic access(input int p, input mem_op_e op, input logic [`MEM_ADDR_W-1:0] addr,
                        input logic [`MEM_LINE_W-1:0] wdata, input bit bp);
    logic [`MEM_LINE_W-1:0] exp;
    logic [`MEM_LINE_W-1:0] held;
    logic                   rdy;
    int                     n;
    string                  tag;
    tag = $sformatf("port %0d read at %h", p, addr);
    exp = '0;
    if (bp) begin
      set_rsp_ready(p, 1'b0);
    end
    drive_req(p, 1'b1, op, addr, wdata);
    n = 0;
    while (!req_ready_of(p)) begin
      wait_cycle(n, "request acceptance");
    end
    // regions differ per writer, so acceptance order is enough.
    if (op == MEM_WRITE) begin
      model_write(addr, wdata);
    end else begin
      exp = model_line(addr);
    end
    @(posedge clk);
    #2;
    drive_req(p, 1'b0, op, addr, wdata);
    n = 0;
    if (op == MEM_WRITE) begin
      while (!req_ready_of(p)) begin
        wait_cycle(n, "write completion");
      end
    end else begin
      while (!rsp_valid_of(p)) begin
        wait_cycle(n, "read response");
      end
      done_time[p] = $time;
      check_line(tag, rsp_rdata_of(p), exp);
      held = rsp_rdata_of(p);
      rdy = 1'b0;
      n = 0;
      while (!rdy) begin
        rdy = bp ? ({$random(seed)} % 4 == 0) : 1'b1;
        check_line("held response", rsp_rdata_of(p), held);
        check_ready("rsp_valid while pending", rsp_valid_of(p), 1'b1);
        check_ready("req_ready while pending", req_ready_of(p), 1'b0);
        set_rsp_ready(p, rdy);
        wait_cycle(n, "response consumption");
      end
      set_rsp_ready(p, 1'b1);
      check_ready("rsp_valid after consume", rsp_valid_of(p), 1'b0);
      check_ready("req_ready after consume", req_ready_of(p), 1'b1);
    end
  endtask

  task automatic traffic_rt(input int p);
    logic [`MEM_ADDR_W-1:0] written [$];
    logic [`MEM_ADDR_W-1:0] addr;
    int                     gap;
    for (int i = 0; i < 40; i++) begin
      gap = {$random(seed)} % 3;
      repeat (gap) begin
        @(posedge clk);
        #2;
      end
      if (written.size() == 0 || {$random(seed)} % 2 == 0) begin
        addr = make_addr({$random(seed)} % `MEM_NUM_GROUP, 384 * p + {$random(seed)} % 377);
        written.push_back(addr);
        access(p, MEM_WRITE, addr, rand_line(), 1'b0);
      end else begin
        addr = written[{$random(seed)} % written.size()];
        access(p, MEM_READ, addr, '0, 1'b0);
      end
    end
  endtask

  task automatic traffic_mc();
    logic [`MEM_ADDR_W-1:0] addr;
    for (int i = 0; i < 40; i++) begin
      addr = make_addr({$random(seed)} % `MEM_NUM_GROUP, 768 + {$random(seed)} % 253);
      access(MC, MEM_READ, addr, '0, 1'b0);
    end
  endtask

  task automatic fill_groups(input int p, input int g0);
    for (int g = g0; g < g0 + 2; g++) begin
      for (int off = 768; off < 1024; off += 4) begin
        access(p, MEM_WRITE, make_addr(g, off), fill_line(make_addr(g, off)), 1'b0);
      end
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == err_base) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: failed with %0d errors", name, errors - err_base);
    end
    err_base = errors;
  endtask

  initial begin
    logic [`MEM_ADDR_W-1:0] a0;
    logic [`MEM_ADDR_W-1:0] a1;
    logic [`MEM_ADDR_W-1:0] a2;
    int                     off;
    int                     first;
    int                     solo;
    seed = 76057;
    errors = 0;
    err_base = 0;
    tests_ok = 0;
    tests_bad = 0;
    rst_n = 1'b0;
    rt_req_valid = '0;
    rt_rsp_ready = '1;
    mc_req_valid = 1'b0;
    mc_req_addr = '0;
    mc_rsp_ready = 1'b1;
    for (int r = 0; r < `MEM_NUM_RT; r++) begin
      rt_req_op[r] = MEM_READ;
      rt_req_addr[r] = '0;
      rt_req_wdata[r] = '0;
    end
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;

    for (int p = 0; p <= MC; p++) begin
      check_ready($sformatf("port %0d req_ready", p), req_ready_of(p), 1'b1);
      check_ready($sformatf("port %0d rsp_valid", p), rsp_valid_of(p), 1'b0);
    end
    finish_test("1 reset state");

    a0 = make_addr(1, 16);
    access(0, MEM_WRITE, a0, rand_line(), 1'b0);
    fork
      access(1, MEM_READ, a0, '0, 1'b0);
      access(MC, MEM_READ, a0, '0, 1'b0);
    join
    finish_test("2 aligned write and reads");

    for (int g = 0; g < `MEM_NUM_GROUP; g++) begin
      for (int i = 0; i < 6; i++) begin
        off = (i < 3) ? 1021 + i : {$random(seed)} % 1024;
        a0 = make_addr(g, off);
        access(i % 2, MEM_WRITE, a0, rand_line(), 1'b0);
        fork
          access(1 - i % 2, MEM_READ, a0, '0, 1'b0);
          access(MC, MEM_READ, a0, '0, 1'b0);
        join
      end
    end
    finish_test("3 unaligned wrap");

    // offsets 768 and up hold known data for the MC reads.
    fork
      fill_groups(0, 0);
      fill_groups(1, 2);
    join
    fork
      traffic_rt(0);
      traffic_rt(1);
      traffic_mc();
    join
    finish_test("4 random concurrent traffic");

    for (int round = 0; round < 6; round++) begin
      solo = round % 2;
      // a lone read makes this port the last one granted in group 2.
      access(solo, MEM_READ, make_addr(2, 768 + {$random(seed)} % 253), '0, 1'b0);
      a0 = make_addr(2, 768 + {$random(seed)} % 253);
      a1 = make_addr(2, 768 + {$random(seed)} % 253);
      a2 = make_addr(2, 768 + {$random(seed)} % 253);
      fork
        access(0, MEM_READ, a0, '0, 1'b0);
        access(1, MEM_READ, a1, '0, 1'b0);
        access(MC, MEM_READ, a2, '0, 1'b0);
      join
      if (done_time[MC] >= done_time[0] || done_time[MC] >= done_time[1]) begin
        errors++;
        $display("[ERROR] %0t: MC read did not finish first in round %0d", $time, round);
      end
      if (done_time[0] == done_time[1]) begin
        errors++;
        $display("[ERROR] %0t: both RT ports served together in one group", $time);
      end
      first = (done_time[0] < done_time[1]) ? 0 : 1;
      if (first == solo) begin
        errors++;
        $display("[ERROR] %0t: RT port %0d served twice in a row", $time, first);
      end
    end
    finish_test("5 same-group contention");

    for (int round = 0; round < 8; round++) begin
      a0 = make_addr({$random(seed)} % `MEM_NUM_GROUP, 768 + {$random(seed)} % 253);
      a1 = make_addr({$random(seed)} % `MEM_NUM_GROUP, 768 + {$random(seed)} % 253);
      a2 = make_addr({$random(seed)} % `MEM_NUM_GROUP, 768 + {$random(seed)} % 253);
      fork
        access(0, MEM_READ, a0, '0, 1'b1);
        access(1, MEM_READ, a1, '0, 1'b1);
        access(MC, MEM_READ, a2, '0, 1'b1);
      join
    end
    finish_test("6 back-pressure");

    $display("tests passed: %0d, tests failed: %0d, errors: %0d", tests_ok, tests_bad, errors);
    if (tests_bad == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+design
design/mem_pkg.sv
design/sp_ram.sv
design/bank_group.sv
design/bank_arbiter.sv
design/rt_port.sv
design/mc_port.sv
design/mem_main.sv
verif/mem_main_tb.sv
